/* verilog/cpld_pkg.sv */
/*
 * Tower board system CPLD shared types
 * Strap, bus and reset structs, sequencer states, register map and RCW codes
 */
package cpld_pkg;

	//*********************************************************************
	// Board straps and SoC bus
	//*********************************************************************
	typedef struct packed {
		logic [3:0] rcw_src;		// One-hot {qspi, sd, hardcode, nor}
		logic       nor_qspi_sel;		// SW2[5]
		logic       diff_sysclk_vsel;	// Single or differential SYSCLK
		logic       bank_sel;		// NOR bank select, SW3[5]
		logic       mux_sel1;		// SerDes default select, SW3[6]
		logic [1:0] cfg_svr;		// Silicon version straps
		logic [1:0] pcb_ver;		// Board revision pins
	} strap_t;

	typedef struct packed {
		logic       cs_b;		// CPLD chip select
		logic       oe_b;		// Read strobe
		logic       we_b;		// Write strobe, rising edge writes
		logic [4:0] addr;		// Register address
		logic [7:0] wdata;		// Write data
	} ifc_bus_t;

	//*********************************************************************
	// Reset control and register file results
	//*********************************************************************
	typedef struct packed {
		logic pwr_hrst_n;		// Hard reset, reloads POR straps
		logic sw_rst_n;			// Soft reset, registers kept
	} rst_ctl_t;

	typedef struct packed {
		logic [7:0] soft_mux_on1;	// Bit 0 enables RCW override
		logic [8:0] rcw_override;	// Software RCW source
		logic       vbank;		// Virtual bank select
		logic [7:0] elev_gpio;		// ELEV connector GPIOs
		logic [3:0] serdes_mux;		// SerDes lane select
		logic       pcie_rst_reg;	// PCIe reset enable, low holds reset
		logic       system_rst;		// Request soft reset
		logic       global_rst;		// Request full POR
	} reg_ctl_t;

	typedef enum logic [1:0] {
		idle       = 2'd0,		// Waiting for supervisor
		system_up  = 2'd1,		// Running
		por_assert = 2'd2,		// POR with strap reload
		swr_assert = 2'd3		// Soft reset of the SoC only
	} seq_state_e;

	typedef enum logic [4:0] {
		addr_ver_major  = 5'd0,
		addr_ver_minor  = 5'd1,
		addr_pcb        = 5'd2,
		addr_system_rst = 5'd3,
		addr_soft_mux   = 5'd4,
		addr_rcw_lo     = 5'd5,
		addr_rcw_hi     = 5'd6,
		addr_vbank      = 5'd7,
		addr_elev_gpio  = 5'd8,
		addr_serdes_mux = 5'd13,
		addr_global_rst = 5'd14,
		addr_pcie_rst   = 5'd20,
		addr_sysclk     = 5'd21
	} reg_addr_e;

	localparam logic [3:0] CPLD_VER_MAJOR = 4'd3;
	localparam logic [3:0] CPLD_VER_MINOR = 4'd3;

	// RCW source codes per switch position
	localparam logic [8:0] RCW_NOR      = 9'b101001000;
	localparam logic [8:0] RCW_HARDCODE = 9'b001110010;
	localparam logic [8:0] RCW_SD       = 9'b000000100;
	localparam logic [8:0] RCW_QSPI     = 9'b001000100;
	localparam logic [8:0] RCW_NONE     = 9'b111111111;

	function automatic logic [8:0] rcw_decode(input logic [3:0] src);
		case (src)
			4'b0001: return RCW_NOR;
			4'b0010: return RCW_HARDCODE;
			4'b0100: return RCW_SD;
			4'b1000: return RCW_QSPI;
			default: return RCW_NONE;	// Zero or several switches on
		endcase
	endfunction

endpackage

/* verilog/input_sync.sv */
/*
 * Two-flop synchronizer for an arbitrary packed payload
 */
`timescale 1ns/1ps

module input_sync #(
	parameter type payload_t = logic
) (
	input  logic     cpld_25MHz,
	input  logic     poreset_b_18,
	input  payload_t d,			// Asynchronous pins
	output payload_t q			// Clock domain copy
);

	payload_t meta;				// First stage, may go metastable

	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
		begin
			meta <= '0;
			q <= '0;
		end
		else
		begin
			meta <= d;
			q <= meta;			// Second stage settles
		end
	end

endmodule

/* verilog/reset_sequencer.sv */
/*
 * Board reset sequencer
 * Walks idle, system up, POR and soft reset states with a minimum hold time
 */
`timescale 1ns/1ps

module reset_sequencer import cpld_pkg::*; #(
	parameter int HOLD_CYCLES = 128
) (
	input  logic     cpld_25MHz,
	input  logic     poreset_b_18,
	input  logic     rst_pld_n,		// Supervisor reset, raw pin
	input  logic     reset_req_b,		// SoC reset request, raw pin
	input  logic     system_rst,		// From register file
	input  logic     global_rst,		// From register file
	output rst_ctl_t rst_ctl
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [1:0]       pin_q;		// {rst_pld_n, reset_req_b} synchronized
	logic             pld_ok;
	logic             req_ok;
	seq_state_e       state;
	seq_state_e       state_nxt;
	logic [CNT_W-1:0] hold_cnt;
	logic             hold_done;
	logic             in_assert;

	input_sync #(
		.payload_t (logic [1:0])
	) i_pin_sync (
		.cpld_25MHz   (cpld_25MHz),
		.poreset_b_18 (poreset_b_18),
		.d            ({rst_pld_n, reset_req_b}),
		.q            (pin_q)
	);

	assign pld_ok = pin_q[1];
	assign req_ok = pin_q[0];

	assign in_assert = (state == por_assert) || (state == swr_assert);
	assign hold_done = (hold_cnt == CNT_W'(HOLD_CYCLES - 1));	// Last held cycle

	//*********************************************************************
	// Next state
	//*********************************************************************
	always_comb
	begin
		state_nxt = state;
		case (state)
			idle:
				if (pld_ok)
					state_nxt = system_up;
			system_up:
				if (!req_ok || !pld_ok || global_rst)
					state_nxt = por_assert;		// Full POR wins
				else if (system_rst)
					state_nxt = swr_assert;
			por_assert:
				if (hold_done && pld_ok)
					state_nxt = system_up;		// Supervisor must be released too
			swr_assert:
				if (hold_done)
					state_nxt = system_up;
			default:
				state_nxt = idle;
		endcase
	end

	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
			state <= idle;
		else
			state <= state_nxt;
	end

	// Hold counter, saturates while POR waits for the supervisor
	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
			hold_cnt <= '0;
		else if (!in_assert)
			hold_cnt <= '0;
		else if (!hold_done)
			hold_cnt <= hold_cnt + 1'b1;
	end

	// Outputs follow the state one clock later
	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
		begin
			rst_ctl.pwr_hrst_n <= 1'b0;
			rst_ctl.sw_rst_n <= 1'b1;
		end
		else
		begin
			rst_ctl.pwr_hrst_n <= (state == system_up) || (state == swr_assert);
			rst_ctl.sw_rst_n <= (state != swr_assert);
		end
	end

endmodule

/* verilog/cpld_regs.sv */
/*
 * CPLD register file
 * Decodes the synchronized flash-controller strobes for register reads and writes
 */
`timescale 1ns/1ps

module cpld_regs import cpld_pkg::*; (
	input  logic      cpld_25MHz,
	input  logic      poreset_b_18,
	input  ifc_bus_t  bus,			// Synchronized bus
	input  strap_t    straps,		// Synchronized straps
	input  rst_ctl_t  rst_ctl,		// From sequencer
	input  logic      sysclksel,		// SYSCLK status switch
	output logic [7:0] rdata,
	output logic      rdata_oe,
	output reg_ctl_t  regs
);

	logic       we_prev;			// Last we_b level
	logic       we_rise;
	logic       rd_active;
	logic [1:0] pcb_rd;
	logic [7:0] rd_mux;
	reg_ctl_t   dflt;			// Strap-dependent defaults

	assign we_rise = bus.we_b && !we_prev && !bus.cs_b;	// Write on we_b rising
	assign rd_active = !bus.cs_b && !bus.oe_b && rst_ctl.pwr_hrst_n;
	assign pcb_rd = straps.pcb_ver + 2'd1;	// Board rev reads one based

	//*********************************************************************
	// Defaults loaded during hard reset
	//*********************************************************************
	always_comb
	begin
		dflt = '0;
		dflt.rcw_override = rcw_decode(straps.rcw_src);
		dflt.vbank = straps.bank_sel;
		dflt.serdes_mux = straps.mux_sel1 ? 4'd14 : 4'd15;
		dflt.pcie_rst_reg = 1'b1;		// PCIe out of reset
	end

	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
			we_prev <= 1'b0;
		else
			we_prev <= bus.we_b;
	end

	//*********************************************************************
	// Register writes
	//*********************************************************************
	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
		begin
			regs <= '0;
			regs.rcw_override <= RCW_NONE;
			regs.serdes_mux <= 4'd15;
			regs.pcie_rst_reg <= 1'b1;
		end
		else if (!rst_ctl.pwr_hrst_n)
			regs <= dflt;			// Follows straps while POR held
		else if (!rst_ctl.sw_rst_n)
			regs.system_rst <= 1'b0;	// Soft reset keeps the rest
		else if (we_rise)
		begin
			case (bus.addr)
				addr_system_rst:
					regs.system_rst <= bus.wdata[0];
				addr_soft_mux:
					regs.soft_mux_on1 <= bus.wdata;
				addr_rcw_lo:
					regs.rcw_override[7:0] <= bus.wdata;
				addr_rcw_hi:
					regs.rcw_override[8] <= bus.wdata[0];
				addr_vbank:
					regs.vbank <= bus.wdata[0];
				addr_elev_gpio:
					regs.elev_gpio <= bus.wdata;
				addr_serdes_mux:
					regs.serdes_mux <= bus.wdata[3:0];
				addr_global_rst:
					regs.global_rst <= bus.wdata[0];
				addr_pcie_rst:
					regs.pcie_rst_reg <= bus.wdata[0];
				default:
					;			// Read-only or unmapped
			endcase
		end
	end

	//*********************************************************************
	// Register reads
	//*********************************************************************
	always_comb
	begin
		case (bus.addr)
			addr_ver_major:  rd_mux = {4'b0, CPLD_VER_MAJOR};
			addr_ver_minor:  rd_mux = {4'b0, CPLD_VER_MINOR};
			addr_pcb:        rd_mux = {6'b0, pcb_rd};
			addr_system_rst: rd_mux = {7'b0, regs.system_rst};
			addr_soft_mux:   rd_mux = regs.soft_mux_on1;
			addr_rcw_lo:     rd_mux = regs.rcw_override[7:0];
			addr_rcw_hi:     rd_mux = {7'b0, regs.rcw_override[8]};
			addr_vbank:      rd_mux = {7'b0, regs.vbank};
			addr_elev_gpio:  rd_mux = regs.elev_gpio;
			addr_serdes_mux: rd_mux = {4'b0, regs.serdes_mux};
			addr_global_rst: rd_mux = {7'b0, regs.global_rst};
			addr_pcie_rst:   rd_mux = {7'b0, regs.pcie_rst_reg};
			addr_sysclk:     rd_mux = {7'b0, sysclksel};
			default:         rd_mux = 8'h00;	// Unmapped
		endcase
	end

	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
			rdata_oe <= 1'b0;
		else
			rdata_oe <= rd_active;		// Drive data bus back to SoC
	end

	always_ff @(posedge cpld_25MHz)
	begin
		rdata <= rd_active ? rd_mux : 8'h00;
	end

endmodule

/* verilog/por_reset_ctrl.sv */
/*
 * POR configuration driver and board reset fan-out
 */
`timescale 1ns/1ps

module por_reset_ctrl import cpld_pkg::*; #(
	parameter int POR_HOLD = 4
) (
	input  logic       cpld_25MHz,
	input  logic       poreset_b_18,
	input  rst_ctl_t   rst_ctl,
	input  reg_ctl_t   regs,
	input  strap_t     straps,
	input  logic       jtag_rst_b,		// JTAG connector reset
	input  logic       k20_trst_b,		// Debug MCU TRST
	input  logic       hreset_b,		// SoC HRESET
	output logic       soc_poreset_b,
	output logic       cpu_trst_b,
	output logic       rst_flsh_n,
	output logic       ddr_rst_b,
	output logic       ethphy_rst_b,
	output logic       rst_pcie_n,
	output logic [8:0] cfg_rcw,		// RCW source strap value
	output logic [1:0] cfg_svr,
	output logic       cfg_sysclk_vsel,
	output logic       cfg_oe		// Strap pins driven
);

	localparam int CNT_W = $clog2(POR_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;		// Cycles since PORESET rose

	assign soc_poreset_b = rst_ctl.pwr_hrst_n && rst_ctl.sw_rst_n && jtag_rst_b;

	assign cpu_trst_b = rst_ctl.pwr_hrst_n && k20_trst_b;
	assign rst_flsh_n = rst_ctl.pwr_hrst_n;
	assign ddr_rst_b = hreset_b;
	assign ethphy_rst_b = hreset_b;
	assign rst_pcie_n = hreset_b && regs.pcie_rst_reg;

	// Software override or switch decode
	assign cfg_rcw = regs.soft_mux_on1[0] ? regs.rcw_override : rcw_decode(straps.rcw_src);
	assign cfg_svr = straps.cfg_svr;
	assign cfg_sysclk_vsel = straps.diff_sysclk_vsel;

	// Hold time on the straps after PORESET negates
	always_ff @(posedge cpld_25MHz or negedge poreset_b_18)
	begin
		if (!poreset_b_18)
		begin
			hold_cnt <= '0;
			cfg_oe <= 1'b0;
		end
		else if (!soc_poreset_b)
		begin
			hold_cnt <= '0;
			cfg_oe <= 1'b1;
		end
		else if (hold_cnt == CNT_W'(POR_HOLD - 1))
			cfg_oe <= 1'b0;		// Release strap pins
		else
			hold_cnt <= hold_cnt + 1'b1;
	end

endmodule

/* verilog/twr_cpld.sv */
/*
 * Tower board system CPLD, reset and POR configuration core
 * Connects the input synchronizers, reset sequencer, registers and reset driver
 */
`timescale 1ns/1ps

module twr_cpld import cpld_pkg::*; #(
	parameter int HOLD_CYCLES = 128,
	parameter int POR_HOLD    = 4
) (
	input  logic       cpld_25MHz,
	input  logic       poreset_b_18,	// Board power-on reset
	input  logic       rcw_src_nor,		// SW2[1]
	input  logic       rcw_src_hdcode,	// SW2[2]
	input  logic       rcw_src_sd,		// SW2[3]
	input  logic       rcw_src_qspi,	// SW2[4]
	input  logic       nor_qspi_sel,
	input  logic       diff_sysclk_vsel,
	input  logic       bank_sel,
	input  logic       mux_sel1,
	input  logic [1:0] cfg_svr_sw,		// SW3[8:7]
	input  logic [1:0] pcb_ver,
	input  logic       ifc_cs_b,
	input  logic       ifc_oe_b,
	input  logic       ifc_we_b,
	input  logic [4:0] ifc_addr,
	input  logic [7:0] ifc_wdata,
	input  logic       sysclksel_96MHz,
	input  logic       rst_pld_n,		// MAX811 supervisor
	input  logic       reset_req_b_18,
	input  logic       jtag_rst_b_18,
	input  logic       k20_trst_b_18,
	input  logic       hreset_b_18,
	output logic [7:0] rdata,
	output logic       rdata_oe,
	output logic       soc_poreset_b,
	output logic       cpu_trst_b,
	output logic       rst_flsh_n,
	output logic       ddr_rst_b,
	output logic       ethphy_rst_b,
	output logic       rst_pcie_n,
	output logic [8:0] cfg_rcw,
	output logic [1:0] cfg_svr,
	output logic       cfg_sysclk_vsel,
	output logic       cfg_oe,
	output logic [7:0] elev_gpio,
	output logic [3:0] serdes_mux
);

	strap_t   strap_raw;
	strap_t   straps;
	ifc_bus_t bus_raw;
	ifc_bus_t bus;
	rst_ctl_t rst_ctl;
	reg_ctl_t regs;

	//*********************************************************************
	// Pin packing and synchronizers
	//*********************************************************************
	assign strap_raw = '{
		rcw_src:          {rcw_src_qspi, rcw_src_sd, rcw_src_hdcode, rcw_src_nor},
		nor_qspi_sel:     nor_qspi_sel,
		diff_sysclk_vsel: diff_sysclk_vsel,
		bank_sel:         bank_sel,
		mux_sel1:         mux_sel1,
		cfg_svr:          cfg_svr_sw,
		pcb_ver:          pcb_ver
	};

	assign bus_raw = '{cs_b: ifc_cs_b, oe_b: ifc_oe_b, we_b: ifc_we_b,
		addr: ifc_addr, wdata: ifc_wdata};

	input_sync #(.payload_t (strap_t)) i_strap_sync (
		.cpld_25MHz   (cpld_25MHz),
		.poreset_b_18 (poreset_b_18),
		.d            (strap_raw),
		.q            (straps)
	);

	input_sync #(.payload_t (ifc_bus_t)) i_bus_sync (
		.cpld_25MHz   (cpld_25MHz),
		.poreset_b_18 (poreset_b_18),
		.d            (bus_raw),
		.q            (bus)
	);

	//*********************************************************************
	// Sequencer, registers and reset driver
	//*********************************************************************
	reset_sequencer #(.HOLD_CYCLES (HOLD_CYCLES)) i_reset_sequencer (
		.cpld_25MHz   (cpld_25MHz),
		.poreset_b_18 (poreset_b_18),
		.rst_pld_n    (rst_pld_n),
		.reset_req_b  (reset_req_b_18),
		.system_rst   (regs.system_rst),
		.global_rst   (regs.global_rst),
		.rst_ctl      (rst_ctl)
	);

	cpld_regs i_cpld_regs (
		.cpld_25MHz   (cpld_25MHz),
		.poreset_b_18 (poreset_b_18),
		.bus          (bus),
		.straps       (straps),
		.rst_ctl      (rst_ctl),
		.sysclksel    (sysclksel_96MHz),
		.rdata        (rdata),
		.rdata_oe     (rdata_oe),
		.regs         (regs)
	);

	por_reset_ctrl #(.POR_HOLD (POR_HOLD)) i_por_reset_ctrl (
		.cpld_25MHz      (cpld_25MHz),
		.poreset_b_18    (poreset_b_18),
		.rst_ctl         (rst_ctl),
		.regs            (regs),
		.straps          (straps),
		.jtag_rst_b      (jtag_rst_b_18),
		.k20_trst_b      (k20_trst_b_18),
		.hreset_b        (hreset_b_18),
		.soc_poreset_b   (soc_poreset_b),
		.cpu_trst_b      (cpu_trst_b),
		.rst_flsh_n      (rst_flsh_n),
		.ddr_rst_b       (ddr_rst_b),
		.ethphy_rst_b    (ethphy_rst_b),
		.rst_pcie_n      (rst_pcie_n),
		.cfg_rcw         (cfg_rcw),
		.cfg_svr         (cfg_svr),
		.cfg_sysclk_vsel (cfg_sysclk_vsel),
		.cfg_oe          (cfg_oe)
	);

	assign elev_gpio = regs.elev_gpio;	// ELEV connector GPIOs
	assign serdes_mux = regs.serdes_mux;	// Lane switch selects

endmodule

/* tb/cpld_model.svh */
/*
 * Reference model for the tower board CPLD testbench
 * Register defaults, RCW switch decode and flash-controller bus tasks
 */
`ifndef CPLD_MODEL_SVH
`define CPLD_MODEL_SVH

localparam int PHASE = 6;			// Cycles per bus strobe phase

logic [7:0] exp_reg [32];			// Expected read value per address

// RCW code from the switch bank, exactly one switch may be on
function automatic logic [8:0] switch_rcw(input logic [3:0] src);
	logic [8:0] code;
	code = RCW_NONE;
	if ($countones(src) == 1)
	begin
		if (src[0])
			code = RCW_NOR;
		else if (src[1])
			code = RCW_HARDCODE;
		else if (src[2])
			code = RCW_SD;
		else
			code = RCW_QSPI;
	end
	return code;
endfunction

// Writable bits per address, zero for read-only and unmapped
function automatic logic [7:0] field_mask(input logic [4:0] addr);
	case (addr)
		5'd4, 5'd5, 5'd8:
			return 8'hff;
		5'd13:
			return 8'h0f;
		5'd3, 5'd6, 5'd7, 5'd14, 5'd20:
			return 8'h01;
		default:
			return 8'h00;
	endcase
endfunction

function automatic bit is_mapped(input logic [4:0] addr);
	return (addr <= 5'd8) || (addr == 5'd13) || (addr == 5'd14) ||
		(addr == 5'd20) || (addr == 5'd21);
endfunction

// Register state right after a hard reset
function automatic void load_defaults(input strap_t s, input logic clk_sel);
	logic [8:0] rcw;
	rcw = switch_rcw(s.rcw_src);
	for (int a = 0; a < 32; a++)
		exp_reg[a] = 8'h00;
	exp_reg[0] = 8'd3;				// Version major
	exp_reg[1] = 8'd3;				// Version minor
	exp_reg[2] = {6'b0, s.pcb_ver + 2'd1};	// Board rev, wraps in 2 bits
	exp_reg[5] = rcw[7:0];
	exp_reg[6] = {7'b0, rcw[8]};
	exp_reg[7] = {7'b0, s.bank_sel};
	exp_reg[13] = s.mux_sel1 ? 8'd14 : 8'd15;
	exp_reg[20] = 8'd1;				// PCIe released
	exp_reg[21] = {7'b0, clk_sel};
endfunction

function automatic void model_write(input logic [4:0] addr, input logic [7:0] data);
	if (field_mask(addr) != 8'h00)
		exp_reg[addr] = data & field_mask(addr);
endfunction

// Write cycle, we_b rises while cs_b is still low
task automatic bus_write(input logic [4:0] addr, input logic [7:0] data);
	@(negedge cpld_25MHz);
	ifc_addr = addr;
	ifc_wdata = data;
	ifc_cs_b = 1'b0;
	ifc_we_b = 1'b0;
	repeat (PHASE) @(negedge cpld_25MHz);
	ifc_we_b = 1'b1;				// Commits the write
	repeat (PHASE) @(negedge cpld_25MHz);
	ifc_cs_b = 1'b1;
	repeat (PHASE) @(negedge cpld_25MHz);
endtask

// Read cycle, data taken at the end of the strobe phase
task automatic bus_read(input logic [4:0] addr, output logic [7:0] data,
	output logic oe_on, output logic oe_off);
	@(negedge cpld_25MHz);
	ifc_addr = addr;
	ifc_cs_b = 1'b0;
	ifc_oe_b = 1'b0;
	repeat (PHASE) @(negedge cpld_25MHz);
	data = rdata;
	oe_on = rdata_oe;
	ifc_cs_b = 1'b1;
	ifc_oe_b = 1'b1;
	repeat (PHASE) @(negedge cpld_25MHz);
	oe_off = rdata_oe;				// Bus must be released by now
endtask

`endif

/* tb/tb_twr_cpld.sv */
/*
 * Testbench for the tower board CPLD reset and POR core
 * Random straps and register traffic checked against a reference model
 */
`timescale 1ns/1ps

module tb_twr_cpld import cpld_pkg::*; ();

	localparam int HOLD_CYCLES = 16;
	localparam int POR_HOLD = 4;
	localparam int PLD_LOW = 3 * HOLD_CYCLES;	// Supervisor hold time in the test

	logic       cpld_25MHz;
	logic       poreset_b_18;
	logic       rcw_src_nor;
	logic       rcw_src_hdcode;
	logic       rcw_src_sd;
	logic       rcw_src_qspi;
	logic       nor_qspi_sel;
	logic       diff_sysclk_vsel;
	logic       bank_sel;
	logic       mux_sel1;
	logic [1:0] cfg_svr_sw;
	logic [1:0] pcb_ver;
	logic       ifc_cs_b;
	logic       ifc_oe_b;
	logic       ifc_we_b;
	logic [4:0] ifc_addr;
	logic [7:0] ifc_wdata;
	logic       sysclksel_96MHz;
	logic       rst_pld_n;
	logic       reset_req_b_18;
	logic       jtag_rst_b_18;
	logic       k20_trst_b_18;
	logic       hreset_b_18;
	logic [7:0] rdata;
	logic       rdata_oe;
	logic       soc_poreset_b;
	logic       cpu_trst_b;
	logic       rst_flsh_n;
	logic       ddr_rst_b;
	logic       ethphy_rst_b;
	logic       rst_pcie_n;
	logic [8:0] cfg_rcw;
	logic [1:0] cfg_svr;
	logic       cfg_sysclk_vsel;
	logic       cfg_oe;
	logic [7:0] elev_gpio;
	logic [3:0] serdes_mux;

	strap_t     sw;				// Current switch settings
	int         errors;
	int         checks;
	int         cycle_cnt;

	`include "cpld_model.svh"

	// Bus accesses in the run, with margin, plus the reset pulses
	localparam int N_ACCESS = 160;
	localparam int MAX_CYCLES = N_ACCESS * (3 * PHASE + 1) + 8 * 4 * HOLD_CYCLES;

	logic [4:0] writable [7] = '{addr_soft_mux, addr_rcw_lo, addr_rcw_hi, addr_vbank,
		addr_elev_gpio, addr_serdes_mux, addr_pcie_rst};
	logic [4:0] mapped [13] = '{addr_ver_major, addr_ver_minor, addr_pcb,
		addr_system_rst, addr_soft_mux, addr_rcw_lo, addr_rcw_hi, addr_vbank,
		addr_elev_gpio, addr_serdes_mux, addr_global_rst, addr_pcie_rst, addr_sysclk};

	twr_cpld #(
		.HOLD_CYCLES (HOLD_CYCLES),
		.POR_HOLD    (POR_HOLD)
	) i_twr_cpld (.*);

	initial
	begin
		cpld_25MHz = 1'b0;
		forever #20 cpld_25MHz = ~cpld_25MHz;	// 25 MHz
	end

	//**********************************************************************
	// Checks
	//**********************************************************************
	task automatic check_hex(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1)
		else
		begin
			errors++;
			$display("Failure at %0t: %s", $time, what);
		end
	endtask

	task automatic check_read(input logic [4:0] addr);
		logic [7:0] data;
		logic oe_on;
		logic oe_off;
		bus_read(addr, data, oe_on, oe_off);
		check_hex($sformatf("rdata @0x%02h", addr), 16'(data), 16'(exp_reg[addr]));
		check_true(oe_on, $sformatf("rdata_oe was low during the read of 0x%02h", addr));
		check_true(!oe_off, "rdata_oe stayed high after the read ended");
	endtask

	// Every mapped register plus the board-facing outputs
	task automatic check_all_regs();
		logic hreset;
		logic trst;
		for (int i = 0; i < 13; i++)
			check_read(mapped[i]);
		hreset = 1'($urandom);
		trst = 1'($urandom);
		@(negedge cpld_25MHz);
		hreset_b_18 = hreset;			// Pass-through resets follow the pins
		k20_trst_b_18 = trst;
		@(negedge cpld_25MHz);
		check_hex("elev_gpio", 16'(elev_gpio), 16'(exp_reg[addr_elev_gpio]));
		check_hex("serdes_mux", 16'(serdes_mux), 16'(exp_reg[addr_serdes_mux]));
		check_hex("rst_pcie_n", 16'(rst_pcie_n), 16'(hreset & exp_reg[addr_pcie_rst][0]));
		check_hex("rst_flsh_n", 16'(rst_flsh_n), 16'h1);
		check_hex("cpu_trst_b", 16'(cpu_trst_b), 16'(trst));
		check_hex("ddr_rst_b", 16'(ddr_rst_b), 16'(hreset));
		check_hex("ethphy_rst_b", 16'(ethphy_rst_b), 16'(hreset));
		check_hex("cfg_svr", 16'(cfg_svr), 16'(sw.cfg_svr));
		check_hex("cfg_sysclk_vsel", 16'(cfg_sysclk_vsel), 16'(sw.diff_sysclk_vsel));
		check_hex("cfg_oe", 16'(cfg_oe), 16'h0);
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
		bus_write(addr, data);
		model_write(addr, data);
	endtask

	// New switch settings, mostly one-hot RCW source
	task automatic randomize_straps();
		int pick;
		sw = 13'($urandom);
		pick = $urandom % 6;
		if (pick < 4)
			sw.rcw_src = 4'b0001 << pick;
		{rcw_src_qspi, rcw_src_sd, rcw_src_hdcode, rcw_src_nor} = sw.rcw_src;
		nor_qspi_sel = sw.nor_qspi_sel;
		diff_sysclk_vsel = sw.diff_sysclk_vsel;
		bank_sel = sw.bank_sel;
		mux_sel1 = sw.mux_sel1;
		cfg_svr_sw = sw.cfg_svr;
		pcb_ver = sw.pcb_ver;
	endtask

	// Follows one PORESET pulse and the strap drive window after it
	task automatic wait_reset_pulse(input logic [8:0] exp_rcw, output int low_len);
		int wait_cnt;
		int high_cnt;
		wait_cnt = 0;
		high_cnt = 0;
		low_len = 0;
		@(negedge cpld_25MHz);
		while (soc_poreset_b && wait_cnt < 8 * PHASE)
		begin
			@(negedge cpld_25MHz);
			wait_cnt++;
		end
		if (soc_poreset_b)
			check_true(1'b0, "soc_poreset_b was never asserted");
		else
		begin
			while (!soc_poreset_b)
			begin
				if (low_len >= 1)
					check_hex("cfg_oe", 16'(cfg_oe), 16'h1);	// Registered one cycle late
				if (low_len >= 2)
					check_hex("cfg_rcw", 16'(cfg_rcw), 16'(exp_rcw));
				low_len++;
				@(negedge cpld_25MHz);
			end
			while (cfg_oe && high_cnt <= POR_HOLD + 2)
			begin
				high_cnt++;
				@(negedge cpld_25MHz);
			end
			check_true(!cfg_oe, "cfg_oe still high POR_HOLD+2 cycles after PORESET release");
			check_true(high_cnt >= POR_HOLD, "cfg_oe released before the strap hold time");
		end
	endtask

	//**********************************************************************
	// Timeout
	//**********************************************************************
	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES)
		begin
			@(posedge cpld_25MHz);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	//**********************************************************************
	// Test sequence
	//**********************************************************************
	initial
	begin
		logic [8:0] override;
		logic [7:0] data;
		logic [4:0] addr;
		int low_len;
		int pick;
		errors = 0;
		checks = 0;
		void'($urandom(18953));
		randomize_straps();
		sysclksel_96MHz = 1'($urandom);
		poreset_b_18 = 1'b0;
		ifc_cs_b = 1'b1;				// Bus idle
		ifc_oe_b = 1'b1;
		ifc_we_b = 1'b1;
		ifc_addr = 5'd0;
		ifc_wdata = 8'h00;
		rst_pld_n = 1'b1;
		reset_req_b_18 = 1'b1;
		jtag_rst_b_18 = 1'b1;
		k20_trst_b_18 = 1'b1;
		hreset_b_18 = 1'b1;
		repeat (2) @(negedge cpld_25MHz);
		poreset_b_18 = 1'b1;

		// Power-on sequencing, identity and defaults
		wait_reset_pulse(switch_rcw(sw.rcw_src), low_len);
		load_defaults(sw, sysclksel_96MHz);
		check_all_regs();
		for (int i = 0; i < 4; i++)
		begin
			addr = 5'($urandom);
			while (is_mapped(addr))
				addr = addr + 5'd1;
			check_read(addr);			// Unmapped reads zero
		end

		// Random writes with read-back
		for (int i = 0; i < 30; i++)
		begin
			pick = $urandom % 7;
			data = 8'($urandom);
			write_reg(writable[pick], data);
			check_read(writable[pick]);
		end

		// Software reset with an RCW override
		override = 9'($urandom);
		write_reg(addr_soft_mux, 8'($urandom) | 8'h01);
		write_reg(addr_rcw_lo, override[7:0]);
		write_reg(addr_rcw_hi, {7'b0, override[8]});
		fork
			bus_write(addr_system_rst, 8'h01);
			wait_reset_pulse(override, low_len);
		join
		check_true(low_len >= HOLD_CYCLES, "software reset shorter than HOLD_CYCLES");
		check_all_regs();				// system_rst back to 0, rest kept

		// Global reset with new switch settings
		randomize_straps();
		repeat (4) @(negedge cpld_25MHz);
		fork
			bus_write(addr_global_rst, 8'h01);
			wait_reset_pulse(switch_rcw(sw.rcw_src), low_len);
		join
		check_true(low_len >= HOLD_CYCLES, "global reset shorter than HOLD_CYCLES");
		load_defaults(sw, sysclksel_96MHz);
		check_all_regs();

		// Reset request pulse from the SoC
		write_reg(addr_elev_gpio, 8'($urandom) | 8'h01);
		check_read(addr_elev_gpio);
		fork
			begin
				@(negedge cpld_25MHz);
				reset_req_b_18 = 1'b0;
				repeat (4) @(negedge cpld_25MHz);
				reset_req_b_18 = 1'b1;
			end
			wait_reset_pulse(switch_rcw(sw.rcw_src), low_len);
		join
		check_true(low_len >= HOLD_CYCLES, "reset request pulse shorter than HOLD_CYCLES");
		load_defaults(sw, sysclksel_96MHz);
		check_all_regs();

		// Supervisor reset held low
		fork
			begin
				@(negedge cpld_25MHz);
				rst_pld_n = 1'b0;
				repeat (PLD_LOW) @(negedge cpld_25MHz);
				rst_pld_n = 1'b1;
			end
			wait_reset_pulse(switch_rcw(sw.rcw_src), low_len);
		join
		check_true(low_len >= PLD_LOW - 4, "soc_poreset_b released while rst_pld_n was low");
		check_all_regs();

		$display("Run complete: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* twr_cpld.f */
+incdir+tb
verilog/cpld_pkg.sv
verilog/input_sync.sv
verilog/reset_sequencer.sv
verilog/cpld_regs.sv
verilog/por_reset_ctrl.sv
verilog/twr_cpld.sv
tb/tb_twr_cpld.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the twr_cpld testbench with Verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f twr_cpld.f --top-module tb_twr_cpld \
	-Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
